/* source/adc_pkg.sv */
// Shared constants for the multislope ADC controller.
// Phase lengths are shortened for simulation and must be scaled for a real integrator.
`default_nettype none

package adc_pkg;

  ////////////////////
  // data widths

  // every tally and every result register
  localparam int CNT_W = 24;

  ////////////////////
  // phase lengths in clk cycles

  localparam int PHASE_W = 16;
  localparam int INIT_WAIT = 40;
  localparam int FIX_POS_LEN = 25;
  localparam int VAR_LEN = 60;
  localparam int FIX_NEG_LEN = 20;
  // decided phases per conversion, two per loop
  localparam int DECISIONS = 8;
  localparam int DEC_W = $clog2(DECISIONS + 1);

  // integrator switch codes, one-hot or zero
  localparam logic [2:0] MUX_OFF = 3'b000;
  // fixed positive reference, drives the integrator down
  localparam logic [2:0] MUX_POS = 3'b001;
  // negative reference, drives the integrator up
  localparam logic [2:0] MUX_NEG = 3'b010;

  ////////////////////
  // serial frame and register map

  // address byte, top bit set means read only
  localparam int ADDR_W = 8;
  localparam int FRAME_W = 32;
  localparam int BIT_W = $clog2(FRAME_W + 1);

  localparam logic [ADDR_W-2:0] REG_LED = 7'd7;
  localparam logic [ADDR_W-2:0] REG_UP = 7'd9;
  localparam logic [ADDR_W-2:0] REG_DOWN = 7'd10;
  localparam logic [ADDR_W-2:0] REG_RUNDOWN = 7'd11;
  localparam logic [ADDR_W-2:0] REG_TRANS_UP = 7'd12;
  localparam logic [ADDR_W-2:0] REG_TRANS_DOWN = 7'd14;
  localparam logic [ADDR_W-2:0] REG_ID = 7'd15;

  // fixed test pattern for link checks
  localparam logic [CNT_W-1:0] ID_VALUE = {CNT_W{1'b1}};

endpackage

`default_nettype wire

/* source/cmpr_sync.sv */
// Comparator synchronizer. The pin is assumed asynchronous to clk.
`default_nettype none

module cmpr_sync (
  input  logic clk,
  input  logic arst_n,
  input  logic cmpr,
  output logic cmpr_level,
  output logic cmpr_cross
);

  // stage 0 and 1 resolve metastability, stage 2 holds the previous level
  logic [2:0] cmpr_sh;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      cmpr_sh <= '0;
    else
      cmpr_sh <= {cmpr_sh[1:0], cmpr};
  end

  assign cmpr_level = cmpr_sh[1];
  // either direction ends the rundown
  assign cmpr_cross = cmpr_sh[2] ^ cmpr_sh[1];

endmodule

`default_nettype wire

/* source/slope_sequencer.sv */
// Multislope phase sequencer. Expects cmpr_level and cmpr_cross already in the clk domain.
// The rundown has no timeout and waits for a comparator crossing.
`default_nettype none

module slope_sequencer (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     cmpr_level,
  input  logic                     cmpr_cross,
  output logic [2:0]               mux,
  output logic                     conv_start,
  output logic                     decide,
  output logic                     decide_up,
  output logic                     snapshot,
  output logic [adc_pkg::CNT_W-1:0] rundown_len,
  output logic                     irq_n
);
  import adc_pkg::*;

  typedef enum logic [3:0] {
    ST_INIT,
    ST_FIX_POS_START,
    ST_FIX_POS,
    ST_VAR_START,
    ST_VAR,
    ST_FIX_NEG_START,
    ST_FIX_NEG,
    ST_VAR2_START,
    ST_VAR2,
    ST_RUNDOWN_START,
    ST_RUNDOWN,
    ST_DONE
  } state_t;

  state_t             state;
  logic [PHASE_W-1:0] timer;
  logic [DEC_W-1:0]   dec_cnt;
  logic [2:0]         pick_mux;

  // comparator high means integrator is low, so drive it up
  assign pick_mux = cmpr_level ? MUX_NEG : MUX_POS;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state       <= ST_INIT;
      timer       <= '0;
      dec_cnt     <= '0;
      mux         <= MUX_OFF;
      conv_start  <= 1'b0;
      decide      <= 1'b0;
      decide_up   <= 1'b0;
      snapshot    <= 1'b0;
      rundown_len <= '0;
      irq_n       <= 1'b1;
    end
    else
    begin
      // timer free runs, each start state clears it
      timer      <= timer + 1'b1;
      conv_start <= 1'b0;
      decide     <= 1'b0;
      snapshot   <= 1'b0;
      irq_n      <= 1'b1;

      case (state)
        ST_INIT:
          if (timer == PHASE_W'(INIT_WAIT - 1))
          begin
            state      <= ST_FIX_POS_START;
            dec_cnt    <= '0;
            conv_start <= 1'b1;
          end

        ////////////////////
        // one loop of four phases

        ST_FIX_POS_START:
        begin
          state <= ST_FIX_POS;
          timer <= '0;
          mux   <= MUX_POS;
        end
        ST_FIX_POS:
          if (timer == PHASE_W'(FIX_POS_LEN - 1))
            state <= ST_VAR_START;

        ST_VAR_START:
        begin
          state     <= ST_VAR;
          timer     <= '0;
          mux       <= pick_mux;
          decide    <= 1'b1;
          decide_up <= cmpr_level;
          dec_cnt   <= dec_cnt + 1'b1;
        end
        ST_VAR:
          if (timer == PHASE_W'(VAR_LEN - 1))
            state <= ST_FIX_NEG_START;

        ST_FIX_NEG_START:
        begin
          state <= ST_FIX_NEG;
          timer <= '0;
          mux   <= MUX_NEG;
        end
        ST_FIX_NEG:
          if (timer == PHASE_W'(FIX_NEG_LEN - 1))
            state <= ST_VAR2_START;

        ST_VAR2_START:
        begin
          state     <= ST_VAR2;
          timer     <= '0;
          mux       <= pick_mux;
          decide    <= 1'b1;
          decide_up <= cmpr_level;
          dec_cnt   <= dec_cnt + 1'b1;
        end
        ST_VAR2:
          if (timer == PHASE_W'(VAR_LEN - 1))
          begin
            // loop again until all decisions are made
            if (dec_cnt == DEC_W'(DECISIONS))
              state <= ST_RUNDOWN_START;
            else
              state <= ST_FIX_POS_START;
          end

        ////////////////////
        // rundown and result hand-off

        // the rundown direction counts as one extra decision
        ST_RUNDOWN_START:
        begin
          state     <= ST_RUNDOWN;
          timer     <= '0;
          mux       <= pick_mux;
          decide    <= 1'b1;
          decide_up <= cmpr_level;
        end
        ST_RUNDOWN:
          if (cmpr_cross)
          begin
            state       <= ST_DONE;
            mux         <= MUX_OFF;
            snapshot    <= 1'b1;
            // cycles spent at the rundown code, including this one
            rundown_len <= CNT_W'(timer) + CNT_W'(1);
          end

        // results are copied this cycle, interrupt follows
        ST_DONE:
        begin
          state <= ST_INIT;
          timer <= '0;
          irq_n <= 1'b0;
        end

        default:
          state <= ST_INIT;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/charge_tally.sv */
// Decision and transition tallies with a result snapshot.
// Counts wrap silently at CNT_W bits.
`default_nettype none

module charge_tally (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      conv_start,
  input  logic                      decide,
  input  logic                      decide_up,
  input  logic                      snapshot,
  input  logic [2:0]                mux,
  input  logic [adc_pkg::CNT_W-1:0] rundown_len,
  output logic [adc_pkg::CNT_W-1:0] res_up,
  output logic [adc_pkg::CNT_W-1:0] res_down,
  output logic [adc_pkg::CNT_W-1:0] res_rundown,
  output logic [adc_pkg::CNT_W-1:0] res_trans_up,
  output logic [adc_pkg::CNT_W-1:0] res_trans_down
);
  import adc_pkg::*;

  logic [CNT_W-1:0] up_cnt;
  logic [CNT_W-1:0] down_cnt;
  logic [CNT_W-1:0] trans_up_cnt;
  logic [CNT_W-1:0] trans_down_cnt;
  // mux one cycle back, for spotting switch changes
  logic [2:0]       mux_q;

  ////////////////////
  // working counts for the running conversion

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      up_cnt         <= '0;
      down_cnt       <= '0;
      trans_up_cnt   <= '0;
      trans_down_cnt <= '0;
      mux_q          <= MUX_OFF;
    end
    else
    begin
      mux_q <= mux;
      if (conv_start)
      begin
        up_cnt         <= '0;
        down_cnt       <= '0;
        trans_up_cnt   <= '0;
        trans_down_cnt <= '0;
      end
      else
      begin
        if (decide && decide_up)
          up_cnt <= up_cnt + 1'b1;
        if (decide && !decide_up)
          down_cnt <= down_cnt + 1'b1;
        // a change into a drive code balances charge injection per switch
        if (mux != mux_q && mux == MUX_NEG)
          trans_up_cnt <= trans_up_cnt + 1'b1;
        if (mux != mux_q && mux == MUX_POS)
          trans_down_cnt <= trans_down_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // result registers, held until the next conversion ends

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      res_up         <= '0;
      res_down       <= '0;
      res_rundown    <= '0;
      res_trans_up   <= '0;
      res_trans_down <= '0;
    end
    else if (snapshot)
    begin
      res_up         <= up_cnt;
      res_down       <= down_cnt;
      res_rundown    <= rundown_len;
      res_trans_up   <= trans_up_cnt;
      res_trans_down <= trans_down_cnt;
    end
  end

endmodule

`default_nettype wire

/* source/spi_target.sv */
// Serial target, oversampled in the clk domain. Each sclk level must last at least 4 clk.
// Mode 0 framing, 8 address bits then 24 data bits, MSB first.
`default_nettype none

module spi_target (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       sclk,
  input  logic                       cs_n,
  input  logic                       mosi,
  output logic                       miso,
  output logic                       rd_req,
  output logic [adc_pkg::ADDR_W-2:0] rd_addr,
  input  logic [adc_pkg::CNT_W-1:0]  rd_data,
  output logic                       wr_en,
  output logic [adc_pkg::ADDR_W-2:0] wr_addr,
  output logic [adc_pkg::CNT_W-1:0]  wr_data
);
  import adc_pkg::*;

  logic [2:0]         sclk_sh;
  logic [2:0]         cs_sh;
  logic [1:0]         mosi_sh;
  logic               sclk_rise;
  logic               sclk_fall;
  logic               cs_rise;
  logic               cs_act;
  logic [BIT_W-1:0]   bit_cnt;
  logic [FRAME_W-1:0] in_sh;
  logic [CNT_W-1:0]   out_sh;
  logic               load_q;

  ////////////////////
  // pin synchronizers

  // all three pins see the same delay so their order is kept
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sclk_sh <= '0;
      cs_sh   <= '1;
      mosi_sh <= '0;
    end
    else
    begin
      sclk_sh <= {sclk_sh[1:0], sclk};
      cs_sh   <= {cs_sh[1:0], cs_n};
      mosi_sh <= {mosi_sh[0], mosi};
    end
  end

  assign sclk_rise = sclk_sh[1] & ~sclk_sh[2];
  assign sclk_fall = ~sclk_sh[1] & sclk_sh[2];
  assign cs_rise   = cs_sh[1] & ~cs_sh[2];
  assign cs_act    = ~cs_sh[1];

  // mosi sampled on rising sclk
  always_ff @(posedge clk)
  begin
    if (cs_act && sclk_rise)
      in_sh <= {in_sh[FRAME_W-2:0], mosi_sh[1]};
  end

  // low address bits right after the address byte, top bit dropped
  assign rd_addr = in_sh[ADDR_W-2:0];
  assign wr_addr = in_sh[FRAME_W-2:CNT_W];
  assign wr_data = in_sh[CNT_W-1:0];

  ////////////////////
  // bit count, read request, write strobe and miso

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt <= '0;
      rd_req  <= 1'b0;
      load_q  <= 1'b0;
      wr_en   <= 1'b0;
      out_sh  <= '0;
      miso    <= 1'b0;
    end
    else
    begin
      rd_req <= cs_act & sclk_rise & (bit_cnt == BIT_W'(ADDR_W - 1));
      // register file answers one cycle after the request
      load_q <= rd_req;
      // write only a complete frame with the read-only bit clear
      wr_en  <= cs_rise & (bit_cnt == BIT_W'(FRAME_W)) & ~in_sh[FRAME_W-1];
      if (!cs_act)
      begin
        bit_cnt <= '0;
        out_sh  <= '0;
        miso    <= 1'b0;
      end
      else
      begin
        // saturate so an overlong frame never looks complete
        if (sclk_rise && bit_cnt != '1)
          bit_cnt <= bit_cnt + 1'b1;
        if (load_q)
          out_sh <= rd_data;
        else if (sclk_fall)
        begin
          miso   <= out_sh[CNT_W-1];
          out_sh <= {out_sh[CNT_W-2:0], 1'b0};
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/reg_file.sv */
// Register map behind the serial port. Unmapped addresses read as zero.
`default_nettype none

module reg_file (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       rd_req,
  input  logic                       wr_en,
  input  logic [adc_pkg::ADDR_W-2:0] rd_addr,
  input  logic [adc_pkg::ADDR_W-2:0] wr_addr,
  input  logic [adc_pkg::CNT_W-1:0]  wr_data,
  input  logic [adc_pkg::CNT_W-1:0]  res_up,
  input  logic [adc_pkg::CNT_W-1:0]  res_down,
  input  logic [adc_pkg::CNT_W-1:0]  res_rundown,
  input  logic [adc_pkg::CNT_W-1:0]  res_trans_up,
  input  logic [adc_pkg::CNT_W-1:0]  res_trans_down,
  output logic [adc_pkg::CNT_W-1:0]  rd_data,
  output logic [adc_pkg::CNT_W-1:0]  led_reg
);
  import adc_pkg::*;

  // led register is the only writable location
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      led_reg <= '0;
    else if (wr_en && wr_addr == REG_LED)
      led_reg <= wr_data;
  end

  // read word captured once per frame
  always_ff @(posedge clk)
  begin
    if (rd_req)
    begin
      case (rd_addr)
        REG_LED:        rd_data <= led_reg;
        REG_UP:         rd_data <= res_up;
        REG_DOWN:       rd_data <= res_down;
        REG_RUNDOWN:    rd_data <= res_rundown;
        REG_TRANS_UP:   rd_data <= res_trans_up;
        REG_TRANS_DOWN: rd_data <= res_trans_down;
        REG_ID:         rd_data <= ID_VALUE;
        default:        rd_data <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/multislope_top.sv */
// Multislope ADC controller top level. All pins besides clk are sampled in the clk domain.
`default_nettype none

module multislope_top (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       cmpr,
  output logic       int_p,
  output logic       int_n,
  output logic       int_sig,
  input  logic       sclk,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  output logic       irq_n,
  output logic [2:0] led_rgb,
  output logic       led_busy
);
  import adc_pkg::*;

  logic                cmpr_level;
  logic                cmpr_cross;
  logic [2:0]          mux;
  logic                conv_start;
  logic                decide;
  logic                decide_up;
  logic                snapshot;
  logic [CNT_W-1:0]    rundown_len;
  logic [CNT_W-1:0]    res_up;
  logic [CNT_W-1:0]    res_down;
  logic [CNT_W-1:0]    res_rundown;
  logic [CNT_W-1:0]    res_trans_up;
  logic [CNT_W-1:0]    res_trans_down;
  logic                rd_req;
  logic                wr_en;
  logic [ADDR_W-2:0]   rd_addr;
  logic [ADDR_W-2:0]   wr_addr;
  logic [CNT_W-1:0]    rd_data;
  logic [CNT_W-1:0]    wr_data;
  logic [CNT_W-1:0]    led_reg;

  // switch order matches the mux code bits
  assign int_p    = mux[0];
  assign int_n    = mux[1];
  assign int_sig  = mux[2];
  assign led_rgb  = led_reg[2:0];
  assign led_busy = ~irq_n;

  ////////////////////
  // modulator

  cmpr_sync cmpr_sync_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmpr       (cmpr),
    .cmpr_level (cmpr_level),
    .cmpr_cross (cmpr_cross)
  );

  slope_sequencer slope_sequencer_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .cmpr_level  (cmpr_level),
    .cmpr_cross  (cmpr_cross),
    .mux         (mux),
    .conv_start  (conv_start),
    .decide      (decide),
    .decide_up   (decide_up),
    .snapshot    (snapshot),
    .rundown_len (rundown_len),
    .irq_n       (irq_n)
  );

  charge_tally charge_tally_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .conv_start     (conv_start),
    .decide         (decide),
    .decide_up      (decide_up),
    .snapshot       (snapshot),
    .mux            (mux),
    .rundown_len    (rundown_len),
    .res_up         (res_up),
    .res_down       (res_down),
    .res_rundown    (res_rundown),
    .res_trans_up   (res_trans_up),
    .res_trans_down (res_trans_down)
  );

  ////////////////////
  // register port

  spi_target spi_target_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .sclk    (sclk),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .miso    (miso),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  reg_file reg_file_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .rd_req         (rd_req),
    .wr_en          (wr_en),
    .rd_addr        (rd_addr),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .res_up         (res_up),
    .res_down       (res_down),
    .res_rundown    (res_rundown),
    .res_trans_up   (res_trans_up),
    .res_trans_down (res_trans_down),
    .rd_data        (rd_data),
    .led_reg        (led_reg)
  );

endmodule

`default_nettype wire

/* bench/multislope_tb.sv */
// Testbench for the multislope ADC controller with a behavioral integrator and comparator.
// Result reads start right after an interrupt so both frames of a pair see the same conversion.
`default_nettype none

module multislope_tb;
  import adc_pkg::*;

  // clk cycles per sclk level
  localparam int HALF_SCLK = 8;
  localparam int LOOP_CYC = FIX_POS_LEN + VAR_LEN + FIX_NEG_LEN + VAR_LEN + 4;
  // mux cycles of all loops before the rundown starts
  localparam int LOOPS_CYC = (DECISIONS / 2) * LOOP_CYC;
  localparam int RUNDOWN_MAX = 200;
  localparam int CONV_CYC = INIT_WAIT + LOOPS_CYC + RUNDOWN_MAX + 3;
  localparam int FRAME_CYC = (FRAME_W + 1) * 2 * HALF_SCLK;
  localparam int FRAME_CNT = 12;
  localparam int CYCLE_LIMIT = 2 * (4 * CONV_CYC + FRAME_CNT * FRAME_CYC);
  // integrator change per cycle before jitter
  localparam int STEP = 4;

  logic             clk;
  logic             arst_n;
  logic             cmpr;
  logic             int_p;
  logic             int_n;
  logic             int_sig;
  logic             sclk;
  logic             cs_n;
  logic             mosi;
  logic             miso;
  logic             irq_n;
  logic [2:0]       led_rgb;
  logic             led_busy;
  logic [2:0]       mux_seen;

  int               errors;
  int               checks;
  int               cycles;
  logic [31:0]      rng_state;
  logic [31:0]      led_rng;
  int               integ;
  int               off_wait;
  logic [2:0]       prev_mux;
  int               off_age;
  int               run_cycles;
  int               trans_up_seen;
  int               trans_down_seen;
  int               last_trans_up;
  int               last_trans_down;
  int               last_rundown;
  int               irq_count;
  int               conv_count;

  multislope_top multislope_top_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .cmpr     (cmpr),
    .int_p    (int_p),
    .int_n    (int_n),
    .int_sig  (int_sig),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso),
    .irq_n    (irq_n),
    .led_rgb  (led_rgb),
    .led_busy (led_busy)
  );

  // switch pins back into a mux code
  assign mux_seen = {int_sig, int_n, int_p};

  initial
  begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  ////////////////////
  // integrator and comparator model

  // comparator high while the integrator sits below zero
  always @(negedge clk)
  begin
    if (!arst_n)
    begin
      integ    = 0;
      off_wait = 8;
      cmpr     = 1'b0;
    end
    else
    begin
      rng_state = xorshift(rng_state);
      if (mux_seen == MUX_NEG)
        integ = integ + STEP + int'(rng_state[1:0]);
      else if (mux_seen == MUX_POS)
        integ = integ - STEP - int'(rng_state[1:0]);
      else if (off_wait == 0)
      begin
        // input charge while the switches are open, sign always flips
        integ    = -integ - 1;
        off_wait = 1 + int'(rng_state[4:0]);
      end
      else
        off_wait = off_wait - 1;
      cmpr = (integ < 0);
    end
  end

  ////////////////////
  // cycle monitor

  always @(negedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("timeout: the run did not finish within %0d clk cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $finish;
    end
    else if (arst_n)
    begin
      checks = checks + 3;
      assert (mux_seen == MUX_OFF || mux_seen == MUX_POS || mux_seen == MUX_NEG)
      else
      begin
        errors = errors + 1;
        $display("[FAIL] %0t: mux code %b is not one-hot or zero", $time, mux_seen);
      end
      // a conversion starts when the switches first close
      if (prev_mux == MUX_OFF && mux_seen != MUX_OFF)
      begin
        run_cycles      = 0;
        trans_up_seen   = 0;
        trans_down_seen = 0;
      end
      if (mux_seen != prev_mux && mux_seen == MUX_NEG)
        trans_up_seen = trans_up_seen + 1;
      if (mux_seen != prev_mux && mux_seen == MUX_POS)
        trans_down_seen = trans_down_seen + 1;
      if (mux_seen != MUX_OFF)
        run_cycles = run_cycles + 1;
      // switches open again on the snapshot cycle
      if (prev_mux != MUX_OFF && mux_seen == MUX_OFF)
      begin
        off_age         = 0;
        conv_count      = conv_count + 1;
        last_trans_up   = trans_up_seen;
        last_trans_down = trans_down_seen;
        last_rundown    = run_cycles - LOOPS_CYC;
      end
      else if (off_age < 1000)
        off_age = off_age + 1;
      // interrupt only on the cycle right after the snapshot
      assert ((irq_n == 1'b0) == (off_age == 1))
      else
      begin
        errors = errors + 1;
        $display("[FAIL] %0t: irq_n is %b %0d cycles after mux went off", $time, irq_n, off_age);
      end
      // busy led lights on the interrupt cycle only
      assert (led_busy === (off_age == 1))
      else
      begin
        errors = errors + 1;
        $display("[FAIL] %0t: led_busy is %b %0d cycles after mux went off", $time, led_busy,
                 off_age);
      end
      if (!irq_n)
        irq_count = irq_count + 1;
      prev_mux = mux_seen;
    end
  end

  ////////////////////
  // serial driver and checks

  task automatic send_frame(input logic [FRAME_W-1:0] word, output logic [CNT_W-1:0] rd_word);
    int i;
    rd_word = '0;
    cs_n    = 1'b0;
    for (i = FRAME_W - 1; i >= 0; i = i - 1)
    begin
      mosi = word[i];
      repeat (HALF_SCLK) @(negedge clk);
      sclk = 1'b1;
      repeat (HALF_SCLK) @(negedge clk);
      // miso settled during the low level
      if (i < CNT_W)
        rd_word[i] = miso;
      sclk = 1'b0;
    end
    repeat (HALF_SCLK) @(negedge clk);
    cs_n = 1'b1;
    mosi = 1'b0;
    repeat (HALF_SCLK) @(negedge clk);
  endtask

  // top address bit set so a read never writes
  task automatic read_reg(input logic [ADDR_W-2:0] addr, output logic [CNT_W-1:0] value);
    send_frame({1'b1, addr, {CNT_W{1'b0}}}, value);
  endtask

  task automatic write_reg(input logic [ADDR_W-2:0] addr, input logic read_only,
                           input logic [CNT_W-1:0] data);
    logic [CNT_W-1:0] unused;
    send_frame({read_only, addr, data}, unused);
  endtask

  task automatic wait_irq;
    @(negedge clk);
    while (irq_n !== 1'b0)
      @(negedge clk);
  endtask

  task automatic expect_equal(input string what, input logic [CNT_W-1:0] got,
                              input logic [CNT_W-1:0] exp);
    checks = checks + 1;
    assert (got === exp)
    else
    begin
      errors = errors + 1;
      $display("[FAIL] %0t: %s is 0x%06h, expected 0x%06h", $time, what, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks = checks + 1;
    assert (cond === 1'b1)
    else
    begin
      errors = errors + 1;
      $display("[FAIL] %0t: %s", $time, what);
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s finished, %0d failures so far", num, name, errors);
  endtask

  initial
  begin : stimulus
    logic [CNT_W-1:0] got_a;
    logic [CNT_W-1:0] got_b;
    logic [CNT_W-1:0] led_val;
    int               exp_a;
    int               exp_b;
    errors          = 0;
    checks          = 0;
    cycles          = 0;
    rng_state       = 32'h884756be;
    led_rng         = xorshift(32'h884756be ^ 32'h5a5a5a5a);
    prev_mux        = MUX_OFF;
    off_age         = 1000;
    run_cycles      = 0;
    trans_up_seen   = 0;
    trans_down_seen = 0;
    last_trans_up   = 0;
    last_trans_down = 0;
    last_rundown    = 0;
    irq_count       = 0;
    conv_count      = 0;
    arst_n          = 1'b0;
    sclk            = 1'b0;
    cs_n            = 1'b1;
    mosi            = 1'b0;
    cmpr            = 1'b0;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // outputs idle after reset
    check_true(mux_seen == MUX_OFF, "mux is not off after reset");
    check_true(irq_n == 1'b1, "irq_n is not high after reset");
    check_true(miso == 1'b0, "miso is not low after reset");
    report_test(1, "reset state");

    // decisions plus the rundown direction
    wait_irq();
    read_reg(REG_UP, got_a);
    read_reg(REG_DOWN, got_b);
    expect_equal("up plus down decisions", got_a + got_b, CNT_W'(DECISIONS + 1));
    report_test(2, "decision counts");

    wait_irq();
    exp_a = last_trans_up;
    exp_b = last_trans_down;
    read_reg(REG_TRANS_UP, got_a);
    read_reg(REG_TRANS_DOWN, got_b);
    expect_equal("transitions into up", got_a, CNT_W'(exp_a));
    expect_equal("transitions into down", got_b, CNT_W'(exp_b));
    check_true(int'(got_a) - int'(got_b) <= 1 && int'(got_b) - int'(got_a) <= 1,
               "transition counts differ by more than one");
    report_test(3, "transition tallies");

    wait_irq();
    exp_a = last_rundown;
    read_reg(REG_RUNDOWN, got_a);
    check_true(got_a != '0, "rundown length reads as zero");
    expect_equal("rundown length", got_a, CNT_W'(exp_a));
    report_test(4, "rundown length");

    // one interrupt per finished conversion, the newest one may still be pending
    check_true(conv_count >= 3 && conv_count - irq_count >= 0 && conv_count - irq_count <= 1,
               "interrupt count does not match the finished conversions");
    report_test(5, "interrupt timing");

    ////////////////////
    // register port

    led_rng = xorshift(led_rng);
    led_val = led_rng[CNT_W-1:0];
    write_reg(REG_LED, 1'b0, led_val);
    expect_equal("led_rgb after write", CNT_W'(led_rgb), CNT_W'(led_val[2:0]));
    read_reg(REG_LED, got_a);
    expect_equal("led register", got_a, led_val);
    write_reg(REG_LED, 1'b1, ~led_val);
    expect_equal("led_rgb after read-only write", CNT_W'(led_rgb), CNT_W'(led_val[2:0]));
    read_reg(REG_LED, got_a);
    expect_equal("led register after read-only write", got_a, led_val);
    read_reg(REG_ID, got_a);
    expect_equal("id register", got_a, {CNT_W{1'b1}});
    read_reg(7'd3, got_a);
    expect_equal("unmapped address", got_a, {CNT_W{1'b0}});
    report_test(6, "register port");

    $display("%0d checks, %0d failed", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* multislope_top.f */
source/adc_pkg.sv
source/cmpr_sync.sv
source/slope_sequencer.sv
source/charge_tally.sv
source/spi_target.sv
source/reg_file.sv
source/multislope_top.sv
bench/multislope_tb.sv
